// File: list.f
rtl/piano_pkg.sv
rtl/ps2_rx.sv
rtl/key_decoder.sv
rtl/key_mapper.sv
rtl/note_divider.sv
rtl/tone_gen.sv
rtl/audio_serializer.sv
rtl/seg_display.sv
rtl/key_piano_top.sv
testbench/key_piano_chk.sv
testbench/key_piano_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal --top-module key_piano_tb \
       -f list.f -o key_piano_sim \
  && ./obj_dir/key_piano_sim | tee sim.log \
  && grep -q "^>>> PASS$" sim.log \
  || { echo "simulation failed"; exit 1; }

// File: testbench/key_piano_tb.sv
`timescale 1ns/1ps
`default_nettype none

module key_piano_tb;

  localparam int HALF        = 20;          // ps/2 half period in clk cycles
  localparam int FRAME_CYC   = 24 * HALF;   // 11 bits plus idle gap
  localparam int LR_CYC      = 256;         // one lrclk period
  localparam int WIN_LONG    = 64;          // lrclk periods per tone window
  localparam int WIN_SHORT   = 16;
  localparam int DISP_CYC    = 3 * 4 * 64;  // three full scans at SCAN_BITS 6
  localparam int N_ITER      = 8;
  localparam int ITER_CYC    = 11 * FRAME_CYC + DISP_CYC + 100
                               + (WIN_LONG + 2 * WIN_SHORT + 4) * LR_CYC;
  localparam int TIMEOUT_CYC = 2 * (16 + N_ITER * ITER_CYC);
  localparam logic signed [15:0] AMP = 16'sh2000;

  // ******************************
  // reference tables in note order a w s e d f t g y h u j
  localparam logic [7:0] SCAN_TBL [1:12] = '{
    8'h1C, 8'h1D, 8'h1B, 8'h24, 8'h23, 8'h2B,
    8'h2C, 8'h34, 8'h35, 8'h33, 8'h3C, 8'h3B
  };
  localparam logic [6:0] LC_TBL [1:12] = '{
    7'h61, 7'h77, 7'h73, 7'h65, 7'h64, 7'h66,
    7'h74, 7'h67, 7'h79, 7'h68, 7'h75, 7'h6A
  };
  localparam int DIV_TBL [1:12] = '{
    191112, 180385, 170261, 160705, 151685, 143172,  // C4 .. F4 as half period - 1
    135136, 127552, 120393, 113635, 107257, 101238   // F#4 .. B4
  };
  localparam logic [6:0] SEG_TBL [0:12] = '{
    7'h7F, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02,  // blank, 1 .. 6
    7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46          // 7 8 9 A b C
  };

  logic        clk, reset, ps2_clk, ps2_data, mode;
  logic [15:0] led;
  logic [6:0]  segs;
  logic [3:0]  ssd_ctl;
  logic        audio_mclk, audio_lrclk, audio_sclk, audio_sdin;

  integer      seed;
  int          errors;
  logic        caps_m;       // model caps lock
  logic [6:0]  letter_m;     // model letter
  logic [3:0]  note_m;       // model current note
  logic [12:1] held_m;       // model held keys
  logic [15:0] des_sr, word, exp_word;
  logic        lr_last;      // lrclk seen at the previous sclk rise
  logic        meas_on;      // tone window open
  logic [15:0] word_last [2];  // 0 left, 1 right
  int          flips [2];
  int          words [2];
  logic        sign_q [2];
  logic        first_q [2];

  key_piano_top #(.FILTER_LEN(4), .SCAN_BITS(6), .AMPLITUDE(AMP)) DUT (
    .clk, .reset, .ps2_clk, .ps2_data, .mode, .led, .segs, .ssd_ctl,
    .audio_mclk, .audio_lrclk, .audio_sclk, .audio_sdin
  );

  always #4 clk = ~clk;  // 8 ns period

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic check_near(input string name, input int exp, input int act, input int tol);
    int act_adj;
    act_adj = (act >= exp - tol && act <= exp + tol) ? exp : act;  // inside band counts as hit
    check(name, exp, act_adj);
  endtask

  function automatic int expected_flips(input int win, input int div);
    return (div == 0) ? 0 : win * LR_CYC / (div + 1);  // silent channel never flips
  endfunction

  task automatic cycles(input int n);
    repeat (n) @(posedge clk);
    #1;  // drive just after the edge
  endtask

  // ******************************
  // ps/2 keyboard side
  task automatic send_frame(input logic [7:0] data, input logic bad);
    logic [10:0] bits;
    bits = {1'b1, (~^data) ^ bad, data, 1'b0};  // stop, odd parity, data, start
    for (int i = 0; i < 11; i++) begin
      ps2_data = bits[i];
      cycles(HALF);
      ps2_clk = 1'b0;  // device samples on the fall
      cycles(HALF);
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    cycles(2 * HALF);  // idle gap
  endtask

  task automatic make_key(input int k);
    send_frame(SCAN_TBL[k], 1'b0);
    held_m[k] = 1'b1;
    note_m    = 4'(k);
    letter_m  = caps_m ? LC_TBL[k] - 7'h20 : LC_TBL[k];  // upper case by offset
  endtask

  task automatic break_key(input int k);
    send_frame(8'hF0, 1'b0);
    send_frame(SCAN_TBL[k], 1'b0);
    held_m[k] = 1'b0;
  endtask

  task automatic tap_caps;
    send_frame(8'h58, 1'b0);
    caps_m = ~caps_m;  // toggles on make only
    send_frame(8'hF0, 1'b0);
    send_frame(8'h58, 1'b0);
  endtask

  task automatic check_leds(input string name);
    cycles(40);
    check({name, " led"}, {caps_m, mode, 7'b0, letter_m}, led);
  endtask

  task automatic check_display;
    logic [6:0] seg_exp;
    int         d3_cyc;
    d3_cyc = 0;
    for (int i = 0; i < DISP_CYC; i++) begin
      seg_exp = (ssd_ctl == 4'b0111) ? SEG_TBL[note_m] : 7'h7F;  // digit 3 only
      if (ssd_ctl == 4'b0111)
        d3_cyc++;
      check("segments", seg_exp, segs);
      cycles(1);
    end
    check("digit 3 share", DISP_CYC / 4, d3_cyc);  // a quarter of every full scan
  endtask

  // ******************************
  // tone window counting sign flips per channel
  task automatic measure(input string name, input int win);
    int div_l, div_r;
    div_l = held_m[note_m] ? DIV_TBL[note_m] : 0;  // released key is silent
    div_r = mode ? div_l / 2 : div_l;  // octave up on the right
    for (int c = 0; c < 2; c++) begin
      flips[c]   = 0;
      words[c]   = 0;
      first_q[c] = 1'b1;
    end
    meas_on = 1'b1;
    while (words[0] < win)
      cycles(1);
    meas_on = 1'b0;
    check_near({name, " left flips"}, expected_flips(win, div_l), flips[0], 1);
    check_near({name, " right model"}, expected_flips(win, div_r), flips[1], 1);
    if (mode)
      check_near({name, " right flips"}, 2 * flips[0], flips[1], 2);
    else
      check_near({name, " right flips"}, flips[0], flips[1], 1);
  endtask

  // audio deserializer where the lsb lands on the first rise of the next half
  always @(posedge audio_sclk) begin
    word = {des_sr[14:0], audio_sdin};
    if (audio_lrclk != lr_last) begin
      word_last[lr_last] = word;
      if (meas_on) begin
        if (held_m[note_m])
          exp_word = word[15] ? -AMP : AMP;
        else
          exp_word = '0;  // released note sends zero words
        check("audio word", exp_word, word);
        if (!first_q[lr_last] && sign_q[lr_last] != word[15])
          flips[lr_last]++;
        sign_q[lr_last]  = word[15];
        first_q[lr_last] = 1'b0;
        words[lr_last]++;
      end
    end
    des_sr  = {des_sr[14:0], audio_sdin};
    lr_last = audio_lrclk;
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYC);
    $display(">>> FAIL");
    $fatal(1, "timeout");
  end

  // ******************************
  // main sequence
  initial begin
    int rnd, k, j;
    seed     = 68401;
    clk      = 1'b0;
    reset    = 1'b1;
    ps2_clk  = 1'b1;  // bus idle high
    ps2_data = 1'b1;
    mode     = 1'b0;
    errors   = 0;
    caps_m   = 1'b0;
    letter_m = '0;
    note_m   = '0;
    held_m   = '0;
    des_sr   = '0;
    lr_last  = 1'b0;
    meas_on  = 1'b0;
    word_last[0] = '0;
    word_last[1] = '0;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    check("reset led", 16'h0, led);
    check("reset digit", 4'b1110, ssd_ctl);
    check("reset segs", 7'h7F, segs);
    check("reset audio", 4'h0, {audio_mclk, audio_lrclk, audio_sclk, audio_sdin});
    for (int it = 0; it < N_ITER; it++) begin
      rnd  = $random(seed);
      mode = rnd[0];
      if (rnd[1])
        tap_caps();
      k = 1 + ($unsigned($random(seed)) % 12);
      make_key(k);
      check_leds("key make");
      check_display();
      measure("tone", WIN_LONG);
      j = (k % 12) + 1;  // another key that is not held
      break_key(j);
      send_frame(8'hE0, 1'b0);  // extended make is ignored
      send_frame(SCAN_TBL[1 + ($unsigned($random(seed)) % 12)], 1'b0);
      send_frame(SCAN_TBL[j], 1'b1);  // bad parity frame is dropped
      check_leds("ignored codes");
      measure("still held", WIN_SHORT);
      break_key(k);
      cycles(2 * LR_CYC);
      check("left silence", 16'h0, word_last[0]);
      check("right silence", 16'h0, word_last[1]);
      measure("released", WIN_SHORT);
    end
    if (errors == 0 && DUT.u_chk.fail_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/key_piano_chk.sv
`timescale 1ns/1ps
`default_nettype none

module key_piano_chk (
  input wire logic       clk,
  input wire logic       reset,
  input wire logic [3:0] ssd_ctl,
  input wire logic       audio_mclk,
  input wire logic       audio_lrclk,
  input wire logic       audio_sclk,
  input wire logic       audio_sdin
);

  logic [7:0] since_rst;     // saturating count of cycles since reset
  int         fail_cnt = 0;  // count of failed assertions

  always_ff @(posedge clk) begin
    if (reset)
      since_rst <= '0;
    else if (since_rst != 8'hFF)
      since_rst <= since_rst + 8'd1;
  end

  // ******************************
  digit_one_cold: assert property (@(posedge clk) disable iff (reset)
    $onehot(~ssd_ctl))
    else begin
      fail_cnt++;
      $error("ssd_ctl is not one-cold");
    end

  sclk_on_mclk: assert property (@(posedge clk) disable iff (reset)
    !$stable(audio_sclk) |-> $fell(audio_mclk))
    else begin
      fail_cnt++;
      $error("sclk moved off the mclk phase");
    end

  sdin_hold: assert property (@(posedge clk) disable iff (reset)
    audio_sclk && $past(audio_sclk) |-> $stable(audio_sdin))
    else begin
      fail_cnt++;
      $error("sdin changed while sclk high");
    end

  lrclk_start_low: assert property (@(posedge clk) disable iff (reset)
    since_rst < 8'd128 |-> !audio_lrclk)
    else begin
      fail_cnt++;
      $error("lrclk rose before the counter wrapped");
    end

endmodule

bind key_piano_top key_piano_chk u_chk (
  .clk(clk), .reset(reset), .ssd_ctl(ssd_ctl), .audio_mclk(audio_mclk),
  .audio_lrclk(audio_lrclk), .audio_sclk(audio_sclk), .audio_sdin(audio_sdin)
);

`default_nettype wire

// File: rtl/key_piano_top.sv
`timescale 1ns/1ps
`default_nettype none

module key_piano_top #(
  parameter int FILTER_LEN = 4,
  parameter int SCAN_BITS  = 16,
  parameter logic signed [piano_pkg::SAMPLE_W-1:0] AMPLITUDE = 16'sh2000
) (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        ps2_clk,
  input  wire logic        ps2_data,
  input  wire logic        mode,
  output logic [15:0]      led,
  output logic [6:0]       segs,     // active low
  output logic [3:0]       ssd_ctl,  // active low
  output logic             audio_mclk,
  output logic             audio_lrclk,
  output logic             audio_sclk,
  output logic             audio_sdin
);

  logic [7:0]                            byte_data;
  logic                                  byte_valid;
  logic                                  key_valid;
  logic [3:0]                            key_index;
  logic                                  key_make;
  logic [12:1]                           key_held;
  logic                                  caps_lock;
  piano_pkg::letter_t                    letter;
  piano_pkg::note_t                      note;
  logic                                  note_on;
  logic [piano_pkg::DIV_W-1:0]           div_left, div_right;
  logic signed [piano_pkg::SAMPLE_W-1:0] sample_left, sample_right;

  assign led = {caps_lock, mode, 7'b0, letter};  // caps, mode, letter

  // ******************************
  // keyboard path
  ps2_rx #(.FILTER_LEN(FILTER_LEN)) u_rx (
    .clk, .reset, .ps2_clk, .ps2_data, .byte_data, .byte_valid
  );

  key_decoder u_dec (
    .clk, .reset, .byte_data, .byte_valid,
    .key_valid, .key_index, .key_make, .key_held
  );

  key_mapper u_map (
    .clk, .reset, .key_valid, .key_index, .key_make, .key_held,
    .caps_lock, .letter, .note, .note_on
  );

  // ******************************
  // tone and audio path
  note_divider u_div (
    .clk, .reset, .note, .note_on, .mode, .div_left, .div_right
  );

  tone_gen #(.AMPLITUDE(AMPLITUDE)) u_tone (
    .clk, .reset, .div_left, .div_right, .sample_left, .sample_right
  );

  audio_serializer u_ser (
    .clk, .reset, .sample_left, .sample_right,
    .audio_mclk, .audio_lrclk, .audio_sclk, .audio_sdin
  );

  // display
  seg_display #(.SCAN_BITS(SCAN_BITS)) u_seg (
    .clk, .reset, .note, .segs, .ssd_ctl
  );

endmodule

`default_nettype wire

// File: rtl/seg_display.sv
`timescale 1ns/1ps
`default_nettype none

module seg_display #(
  parameter int SCAN_BITS = 16  // digit period = 2^SCAN_BITS cycles
) (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire piano_pkg::note_t  note,
  output logic [6:0]             segs,
  output logic [3:0]             ssd_ctl
);

  logic [SCAN_BITS-1:0] scan_cnt;
  logic [3:0]           digit_sel;  // one-cold, active low enables
  logic                 scan_tick;

  assign scan_tick = &scan_cnt;
  assign ssd_ctl   = digit_sel;

  // ******************************
  // digit scan
  always_ff @(posedge clk) begin
    if (reset) begin
      scan_cnt  <= '0;
      digit_sel <= 4'b1110;  // digit 0 first
    end else begin
      scan_cnt <= scan_cnt + 1'b1;
      if (scan_tick)
        digit_sel <= {digit_sel[2:0], digit_sel[3]};  // rotate
    end
  end

  // only digit 3 carries the note, blank when none
  always_comb begin
    if (!digit_sel[3] && note != 4'd0)
      segs = piano_pkg::SEG_HEX[note];
    else
      segs = piano_pkg::SEG_BLANK;
  end

endmodule

`default_nettype wire

// File: rtl/audio_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module audio_serializer (
  input  wire logic                                clk,
  input  wire logic                                reset,
  input  wire logic signed [piano_pkg::SAMPLE_W-1:0] sample_left,
  input  wire logic signed [piano_pkg::SAMPLE_W-1:0] sample_right,
  output logic                                     audio_mclk,
  output logic                                     audio_lrclk,
  output logic                                     audio_sclk,
  output logic                                     audio_sdin
);

  logic [7:0]                    cnt;       // free-running clock divider
  logic                          sclk_fall; // sclk about to fall
  logic                          lr_edge;   // lrclk about to toggle
  logic [piano_pkg::SAMPLE_W-1:0] shift_sr;

  assign audio_mclk  = cnt[1];  // clk / 4
  assign audio_sclk  = cnt[2];  // clk / 8
  assign audio_lrclk = cnt[7];  // clk / 256, low = left

  assign sclk_fall = (cnt[2:0] == 3'b111);
  assign lr_edge   = (cnt[6:0] == 7'h7F);  // also a sclk fall

  always_ff @(posedge clk) begin
    if (reset)
      cnt <= '0;
    else
      cnt <= cnt + 8'd1;
  end

  // ******************************
  // shift out msb first, one sclk after lrclk
  always_ff @(posedge clk) begin
    if (reset) begin
      shift_sr   <= '0;
      audio_sdin <= 1'b0;
    end else if (sclk_fall) begin
      audio_sdin <= shift_sr[piano_pkg::SAMPLE_W-1];  // last bit of word
      if (lr_edge)
        shift_sr <= cnt[7] ? sample_left : sample_right;  // next channel
      else
        shift_sr <= {shift_sr[piano_pkg::SAMPLE_W-2:0], 1'b0};  // zero fill
    end
  end

endmodule

`default_nettype wire

// File: rtl/tone_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tone_gen #(
  parameter logic signed [piano_pkg::SAMPLE_W-1:0] AMPLITUDE = 16'sh2000
) (
  input  wire logic                                  clk,
  input  wire logic                                  reset,
  input  wire logic [piano_pkg::DIV_W-1:0]           div_left,
  input  wire logic [piano_pkg::DIV_W-1:0]           div_right,
  output logic signed [piano_pkg::SAMPLE_W-1:0]      sample_left,
  output logic signed [piano_pkg::SAMPLE_W-1:0]      sample_right
);

  logic [piano_pkg::DIV_W-1:0]           div_in [2];  // 0 left, 1 right
  logic signed [piano_pkg::SAMPLE_W-1:0] sample [2];

  assign div_in[0]    = div_left;
  assign div_in[1]    = div_right;
  assign sample_left  = sample[0];
  assign sample_right = sample[1];

  // ******************************
  // one half-period counter per channel
  for (genvar ch = 0; ch < 2; ch++) begin : g_ch
    logic [piano_pkg::DIV_W-1:0] cnt;
    logic [piano_pkg::DIV_W-1:0] div_q;  // divider in use
    logic                        pol;    // 1 = negative half

    always_ff @(posedge clk) begin
      if (reset) begin
        cnt   <= '0;
        div_q <= '0;
        pol   <= 1'b0;
      end else if (div_in[ch] != div_q) begin
        div_q <= div_in[ch];  // new pitch, restart
        cnt   <= '0;
        pol   <= 1'b0;
      end else if (div_q != '0) begin
        if (cnt == div_q) begin
          cnt <= '0;
          pol <= ~pol;  // flip every div+1 cycles
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end

    assign sample[ch] = (div_q == '0) ? '0 : (pol ? -AMPLITUDE : AMPLITUDE);
  end

endmodule

`default_nettype wire

// File: rtl/note_divider.sv
`timescale 1ns/1ps
`default_nettype none

module note_divider (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire piano_pkg::note_t            note,
  input  wire logic                        note_on,
  input  wire logic                        mode,
  output logic [piano_pkg::DIV_W-1:0]      div_left,
  output logic [piano_pkg::DIV_W-1:0]      div_right
);

  logic [piano_pkg::DIV_W-1:0] div_tbl;  // half period - 1, 100 MHz

  // ******************************
  // equal temperament from C4
  always_comb begin
    case (note)
      4'd1:    div_tbl = 20'd191112;  // C4
      4'd2:    div_tbl = 20'd180385;  // C#4
      4'd3:    div_tbl = 20'd170261;  // D4
      4'd4:    div_tbl = 20'd160705;  // D#4
      4'd5:    div_tbl = 20'd151685;  // E4
      4'd6:    div_tbl = 20'd143172;  // F4
      4'd7:    div_tbl = 20'd135136;  // F#4
      4'd8:    div_tbl = 20'd127552;  // G4
      4'd9:    div_tbl = 20'd120393;  // G#4
      4'd10:   div_tbl = 20'd113635;  // A4
      4'd11:   div_tbl = 20'd107257;  // A#4
      4'd12:   div_tbl = 20'd101238;  // B4
      default: div_tbl = '0;          // no note, silent
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      div_left  <= '0;
      div_right <= '0;
    end else if (!note_on) begin
      div_left  <= '0;  // key released
      div_right <= '0;
    end else begin
      div_left  <= div_tbl;
      div_right <= mode ? (div_tbl >> 1) : div_tbl;  // octave up in mode 1
    end
  end

endmodule

`default_nettype wire

// File: rtl/key_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module key_mapper (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              key_valid,
  input  wire logic [3:0]        key_index,
  input  wire logic              key_make,
  input  wire logic [12:1]       key_held,
  output logic                   caps_lock,
  output piano_pkg::letter_t     letter,
  output piano_pkg::note_t       note,
  output logic                   note_on
);

  // lower-case ascii of each piano key, note order
  localparam logic [12:1][6:0] LETTER_LC = {
    7'h6A, 7'h75, 7'h68, 7'h79,  // j u h y
    7'h67, 7'h74, 7'h66, 7'h64,  // g t f d
    7'h65, 7'h73, 7'h77, 7'h61   // e s w a
  };

  logic [12:1]        cur_mask;  // held bit of the current note
  piano_pkg::letter_t lc;

  assign cur_mask = 12'b1 << (note - 4'd1);  // note 0 shifts out to zero
  assign lc       = LETTER_LC[key_index];

  // ******************************
  // caps, letter and note registers
  always_ff @(posedge clk) begin
    if (reset) begin
      caps_lock <= 1'b0;
      letter    <= '0;
      note      <= '0;
      note_on   <= 1'b0;
    end else begin
      if (key_valid && key_make) begin
        if (key_index == piano_pkg::KEY_CAPS) begin
          caps_lock <= ~caps_lock;  // repeat makes toggle again
        end else begin
          note   <= key_index;
          letter <= caps_lock ? (lc & 7'h5F) : lc;  // clear bit 5 for upper
        end
      end
      note_on <= |(key_held & cur_mask);  // drops the cycle after the break
    end
  end

endmodule

`default_nettype wire

// File: rtl/key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic [7:0]  byte_data,
  input  wire logic        byte_valid,
  output logic             key_valid,
  output logic [3:0]       key_index,
  output logic             key_make,
  output logic [12:1]      key_held
);

  logic        brk;        // F0 seen
  logic        ext;        // E0 seen
  logic [12:1] hit;        // piano key match, one-hot
  logic        hit_caps;
  logic [3:0]  hit_index;  // encoded match, 0 if none

  // ******************************
  // scan code match
  always_comb begin
    hit_index = '0;
    for (int i = 1; i <= 12; i++) begin
      hit[i] = (byte_data == piano_pkg::piano_scan[i]);
      if (hit[i])
        hit_index = 4'(i);
    end
    hit_caps = (byte_data == piano_pkg::SC_CAPS);
    if (hit_caps)
      hit_index = piano_pkg::KEY_CAPS;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      brk       <= 1'b0;
      ext       <= 1'b0;
      key_valid <= 1'b0;
      key_index <= '0;
      key_make  <= 1'b0;
      key_held  <= '0;
    end else begin
      key_valid <= 1'b0;
      if (byte_valid) begin
        if (byte_data == piano_pkg::SC_BREAK) begin
          brk <= 1'b1;  // prefix only, no event
        end else if (byte_data == piano_pkg::SC_EXT) begin
          ext <= 1'b1;
        end else begin
          brk <= 1'b0;  // code ends the sequence
          ext <= 1'b0;
          if (!ext && hit_index != 4'd0) begin
            key_valid <= 1'b1;
            key_index <= hit_index;
            key_make  <= ~brk;
            for (int i = 1; i <= 12; i++)
              if (hit[i])
                key_held[i] <= ~brk;  // make sets, break clears
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/ps2_rx.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_rx #(
  parameter int FILTER_LEN = 4  // glitch filter depth in clk cycles
) (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       ps2_clk,
  input  wire logic       ps2_data,
  output logic [7:0]      byte_data,
  output logic            byte_valid
);

  logic [1:0]            clk_sync;   // two-flop sync, ps2 clock
  logic [1:0]            data_sync;  // two-flop sync, ps2 data
  logic [FILTER_LEN-1:0] filt_sr;    // history of synced clock
  logic                  clk_f;      // filtered ps2 clock
  logic                  fall;       // filtered clock falling edge
  logic [3:0]            bit_cnt;    // 0 start .. 10 stop
  logic [9:0]            frame_sr;   // parity, data, start; lsb first
  logic                  data_s;

  assign data_s = data_sync[1];
  assign fall   = clk_f & ~|filt_sr;  // steady low after being high

  always_ff @(posedge clk) begin
    if (reset) begin
      clk_sync  <= 2'b11;  // bus idles high
      data_sync <= 2'b11;
      filt_sr   <= '1;
      clk_f     <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      filt_sr   <= {filt_sr[FILTER_LEN-2:0], clk_sync[1]};
      if (&filt_sr)
        clk_f <= 1'b1;  // steady high
      else if (~|filt_sr)
        clk_f <= 1'b0;  // steady low
    end
  end

  // ******************************
  // frame assembly
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;  // one-cycle strobe
      if (fall) begin
        if (bit_cnt == 4'd10) begin
          bit_cnt <= '0;
          // start 0, stop 1, odd parity over data + parity bit
          if (!frame_sr[0] && data_s && ^frame_sr[9:1])
            byte_valid <= 1'b1;
        end else if (bit_cnt != 4'd0 || !data_s) begin
          bit_cnt <= bit_cnt + 4'd1;  // idle high at bit 0 keeps us waiting
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fall && bit_cnt != 4'd10)
      frame_sr <= {data_s, frame_sr[9:1]};  // shift in lsb first
    if (fall && bit_cnt == 4'd10)
      byte_data <= frame_sr[8:1];
  end

endmodule

`default_nettype wire

// File: rtl/piano_pkg.sv
`default_nettype none

package piano_pkg;

  // ******************************
  // shared types
  typedef logic [3:0] note_t;    // 0 = none, 1..12 = notes
  typedef logic [6:0] letter_t;  // ascii letter for the leds

  localparam int DIV_W    = 20;  // half-period divider width
  localparam int SAMPLE_W = 16;  // audio sample width

  // ******************************
  // ps/2 set 2 scan codes
  localparam logic [7:0] SC_BREAK = 8'hF0;  // break prefix
  localparam logic [7:0] SC_EXT   = 8'hE0;  // extended prefix
  localparam logic [7:0] SC_CAPS  = 8'h58;  // caps lock make
  localparam logic [3:0] KEY_CAPS = 4'd13;  // decoder index for caps

  // make codes of the piano keys, indexed by note
  localparam logic [12:1][7:0] piano_scan = {
    8'h3B, 8'h3C, 8'h33, 8'h35,  // j u h y
    8'h34, 8'h2C, 8'h2B, 8'h23,  // g t f d
    8'h24, 8'h1B, 8'h1D, 8'h1C   // e s w a
  };

  // ******************************
  // seven segment, active low, {g,f,e,d,c,b,a}
  localparam logic [6:0] SEG_BLANK = 7'h7F;  // all segments off
  localparam logic [15:0][6:0] SEG_HEX = {
    7'h0E, 7'h06, 7'h21, 7'h46,  // F E d C
    7'h03, 7'h08, 7'h10, 7'h00,  // b A 9 8
    7'h78, 7'h02, 7'h12, 7'h19,  // 7 6 5 4
    7'h30, 7'h24, 7'h79, 7'h40   // 3 2 1 0
  };

endpackage

`default_nettype wire
